// ==== common/cpu_pkg.sv ====
`default_nettype none

package cpu_pkg;

    typedef logic [31:0] word_t;
    typedef logic [31:0] inst_addr_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [15:0] half_t;

    localparam int         num_regs = 32;
    localparam reg_addr_t  reg_zero = 5'd0;
    localparam inst_addr_t pc_step  = 32'd4;

    // major opcodes
    localparam logic [5:0] opcode_special = 6'b000000;
    localparam logic [5:0] opcode_andi    = 6'b001100;
    localparam logic [5:0] opcode_ori     = 6'b001101;
    localparam logic [5:0] opcode_xori    = 6'b001110;
    localparam logic [5:0] opcode_lui     = 6'b001111;

    // function field of the SPECIAL group
    localparam logic [5:0] funct_and = 6'b100100;
    localparam logic [5:0] funct_or  = 6'b100101;
    localparam logic [5:0] funct_xor = 6'b100110;
    localparam logic [5:0] funct_nor = 6'b100111;

    // one instruction word, seen as I-type or R-type
    typedef union packed {
        struct packed {
            logic [5:0] opcode;
            reg_addr_t  rs;
            reg_addr_t  rt;
            half_t      imm;
        } i;
        struct packed {
            logic [5:0] opcode;
            reg_addr_t  rs;
            reg_addr_t  rt;
            reg_addr_t  rd;
            logic [4:0] shamt;
            logic [5:0] funct;
        } r;
    } inst_u;

    typedef enum logic [2:0] {
        op_nop = 3'd0,
        op_or  = 3'd1,
        op_and = 3'd2,
        op_xor = 3'd3,
        op_nor = 3'd4,
        op_lui = 3'd5
    } oper_e;

    // decode to execute
    typedef struct packed {
        oper_e     oper;
        word_t     op1;
        word_t     op2;
        logic      we;
        reg_addr_t waddr;
    } id_ex_t;

    // execute result toward the register file
    typedef struct packed {
        logic      we;
        reg_addr_t waddr;
        word_t     wdata;
    } wb_t;

endpackage

`default_nettype wire

// ==== source/fetch.sv ====
`default_nettype none

module fetch
    import cpu_pkg::*;
(
    input  wire             clk_i,
    input  wire             reset_i,
    output inst_addr_t      inst_addr_o,
    input  wire word_t      inst_i,
    output inst_u           if_inst_o
);

    inst_addr_t pc;

    assign inst_addr_o = pc;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            pc <= '0;
        end else begin
            pc <= pc + pc_step;
        end
    end

    // IF/ID latch, all zeros decodes as a nop
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            if_inst_o <= '0;
        end else begin
            if_inst_o <= inst_i;
        end
    end

endmodule

`default_nettype wire

// ==== decode/regfile.sv ====
`default_nettype none

module regfile
    import cpu_pkg::*;
(
    input  wire             clk_i,
    input  wire             reset_i,
    input  wire             reg1_read_i,
    input  wire             reg2_read_i,
    input  wire reg_addr_t  reg1_addr_i,
    input  wire reg_addr_t  reg2_addr_i,
    output word_t           reg1_data_o,
    output word_t           reg2_data_o,
    input  wire wb_t        wb_i
);

    word_t regs [num_regs];

    // a write landing this cycle is returned before it is stored
    function automatic word_t read_port(
        input logic      rd_en,
        input reg_addr_t addr,
        input word_t     stored,
        input wb_t       wb
    );
        word_t val;
        if (!rd_en || addr == reg_zero) begin
            val = '0;
        end else if (wb.we && wb.waddr == addr) begin
            val = wb.wdata;
        end else begin
            val = stored;
        end
        return val;
    endfunction

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            for (int i = 0; i < num_regs; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_i.we && wb_i.waddr != reg_zero) begin
            regs[wb_i.waddr] <= wb_i.wdata;
        end
    end

    assign reg1_data_o = read_port(reg1_read_i, reg1_addr_i, regs[reg1_addr_i], wb_i);
    assign reg2_data_o = read_port(reg2_read_i, reg2_addr_i, regs[reg2_addr_i], wb_i);

endmodule

`default_nettype wire

// ==== decode/id.sv ====
`default_nettype none

module id
    import cpu_pkg::*;
(
    input  wire inst_u      if_inst_i,
    output logic            reg1_read_o,
    output logic            reg2_read_o,
    output reg_addr_t       reg1_addr_o,
    output reg_addr_t       reg2_addr_o,
    input  wire word_t      reg1_data_i,
    input  wire word_t      reg2_data_i,
    input  wire wb_t        ex_fwd_i,
    output id_ex_t          id_ex_o
);

    oper_e     oper;
    oper_e     special_oper;
    logic      wreg;
    reg_addr_t waddr;
    word_t     imm_ext;

    // forwarded execute result wins over register data
    function automatic word_t pick_operand(
        input logic      rd_en,
        input reg_addr_t addr,
        input word_t     rf_data,
        input wb_t       fwd,
        input word_t     imm
    );
        word_t val;
        if (!rd_en) begin
            val = imm;
        end else if (fwd.we && fwd.waddr == addr && addr != reg_zero) begin
            val = fwd.wdata;
        end else begin
            val = rf_data;
        end
        return val;
    endfunction

    assign imm_ext     = {16'h0000, if_inst_i.i.imm};
    assign reg1_addr_o = if_inst_i.i.rs;
    assign reg2_addr_o = if_inst_i.i.rt;

    always_comb begin
        case (if_inst_i.r.funct)
            funct_or:  special_oper = op_or;
            funct_and: special_oper = op_and;
            funct_xor: special_oper = op_xor;
            funct_nor: special_oper = op_nor;
            default:   special_oper = op_nop;
        endcase
    end

    always_comb begin
        oper        = op_nop;
        wreg        = 1'b0;
        waddr       = if_inst_i.i.rt;
        reg1_read_o = 1'b0;
        reg2_read_o = 1'b0;
        case (if_inst_i.i.opcode)
            opcode_ori: begin
                oper        = op_or;
                wreg        = 1'b1;
                reg1_read_o = 1'b1;
            end
            opcode_andi: begin
                oper        = op_and;
                wreg        = 1'b1;
                reg1_read_o = 1'b1;
            end
            opcode_xori: begin
                oper        = op_xor;
                wreg        = 1'b1;
                reg1_read_o = 1'b1;
            end
            // upper half is placed in execute
            opcode_lui: begin
                oper = op_lui;
                wreg = 1'b1;
            end
            opcode_special: begin
                oper  = special_oper;
                waddr = if_inst_i.r.rd;
                if (special_oper != op_nop) begin
                    wreg        = 1'b1;
                    reg1_read_o = 1'b1;
                    reg2_read_o = 1'b1;
                end
            end
            default: begin
            end
        endcase
    end

    assign id_ex_o.oper  = oper;
    assign id_ex_o.we    = wreg;
    assign id_ex_o.waddr = waddr;
    assign id_ex_o.op1   = pick_operand(reg1_read_o, reg1_addr_o, reg1_data_i, ex_fwd_i, '0);
    assign id_ex_o.op2   = pick_operand(reg2_read_o, reg2_addr_o, reg2_data_i, ex_fwd_i, imm_ext);

endmodule

`default_nettype wire

// ==== source/ex.sv ====
`default_nettype none

module ex
    import cpu_pkg::*;
(
    input  wire             clk_i,
    input  wire             reset_i,
    input  wire id_ex_t     id_ex_i,
    output wb_t             ex_fwd_o,
    output wb_t             wb_o
);

    id_ex_t id_ex_q;
    word_t  result;

    // ID/EX register, operands carry no reset
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            id_ex_q.oper <= op_nop;
            id_ex_q.we   <= 1'b0;
        end else begin
            id_ex_q <= id_ex_i;
        end
    end

    always_comb begin
        case (id_ex_q.oper)
            op_or: begin
                result = id_ex_q.op1 | id_ex_q.op2;
            end
            op_and: begin
                result = id_ex_q.op1 & id_ex_q.op2;
            end
            op_xor: begin
                result = id_ex_q.op1 ^ id_ex_q.op2;
            end
            op_nor: begin
                result = ~(id_ex_q.op1 | id_ex_q.op2);
            end
            op_lui: begin
                result = {id_ex_q.op2[15:0], 16'h0000};
            end
            default: begin
                result = '0;
            end
        endcase
    end

    // also seen by decode for forwarding
    assign ex_fwd_o.we    = id_ex_q.we;
    assign ex_fwd_o.waddr = id_ex_q.waddr;
    assign ex_fwd_o.wdata = result;

    // EX/WB register
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            wb_o.we <= 1'b0;
        end else begin
            wb_o <= ex_fwd_o;
        end
    end

endmodule

`default_nettype wire

// ==== source/cpu_top.sv ====
`default_nettype none

module cpu_top
    import cpu_pkg::*;
(
    input  wire             clk_i,
    input  wire             reset_i,
    output inst_addr_t      inst_addr_o,
    input  wire word_t      inst_i,
    output wb_t             wb_o
);

    inst_u     if_inst;
    logic      reg1_read;
    logic      reg2_read;
    reg_addr_t reg1_addr;
    reg_addr_t reg2_addr;
    word_t     reg1_data;
    word_t     reg2_data;
    id_ex_t    id_ex;
    wb_t       ex_fwd;

    fetch u_fetch (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .inst_addr_o (inst_addr_o),
        .inst_i      (inst_i),
        .if_inst_o   (if_inst)
    );

    id u_id (
        .if_inst_i   (if_inst),
        .reg1_read_o (reg1_read),
        .reg2_read_o (reg2_read),
        .reg1_addr_o (reg1_addr),
        .reg2_addr_o (reg2_addr),
        .reg1_data_i (reg1_data),
        .reg2_data_i (reg2_data),
        .ex_fwd_i    (ex_fwd),
        .id_ex_o     (id_ex)
    );

    // written from the registered write-back stage
    regfile u_regfile (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .reg1_read_i (reg1_read),
        .reg2_read_i (reg2_read),
        .reg1_addr_i (reg1_addr),
        .reg2_addr_i (reg2_addr),
        .reg1_data_o (reg1_data),
        .reg2_data_o (reg2_data),
        .wb_i        (wb_o)
    );

    ex u_ex (
        .clk_i    (clk_i),
        .reset_i  (reset_i),
        .id_ex_i  (id_ex),
        .ex_fwd_o (ex_fwd),
        .wb_o     (wb_o)
    );

endmodule

`default_nettype wire

// ==== dv/cpu_assertions.sv ====
`default_nettype none

module cpu_assertions
    import cpu_pkg::*;
(
    input wire             clk_i,
    input wire             reset_i,
    input wire inst_addr_t inst_addr_i,
    input wire wb_t        wb_i
);

    timeunit 1ns;
    timeprecision 1ps;

    int unsigned error_count = 0;
    int unsigned since_reset;

    // cycles since reset, saturating
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            since_reset <= 0;
        end else if (since_reset < 8) begin
            since_reset <= since_reset + 1;
        end
    end

    reset_state: assert property (@(posedge clk_i)
        $past(reset_i) |-> (inst_addr_i == '0) && !wb_i.we)
    else begin
        error_count++;
        $error("pc or write-back enable not cleared by reset");
    end

    pc_step_check: assert property (@(posedge clk_i) disable iff (reset_i)
        !$past(reset_i) |-> inst_addr_i == $past(inst_addr_i) + pc_step)
    else begin
        error_count++;
        $error("pc did not step by 4");
    end

    // pipeline is still filling for three cycles
    wb_quiet: assert property (@(posedge clk_i) disable iff (reset_i)
        since_reset < 3 |-> !wb_i.we)
    else begin
        error_count++;
        $error("write-back seen before cycle 3");
    end

    wb_known: assert property (@(posedge clk_i) disable iff (reset_i)
        wb_i.we |-> !$isunknown({wb_i.waddr, wb_i.wdata}))
    else begin
        error_count++;
        $error("write-back address or data unknown");
    end

endmodule

bind cpu_top cpu_assertions u_assertions (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .inst_addr_i (inst_addr_o),
    .wb_i        (wb_o)
);

`default_nettype wire

// ==== dv/cpu_tb.sv ====
`default_nettype none

module cpu_tb
    import cpu_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int max_prog  = 64;
    localparam int rows      = max_prog + 3;
    localparam int max_tests = 8;
    localparam int wb_delay  = 3;

    logic       clk;
    logic       reset;
    inst_addr_t inst_addr;
    word_t      inst;
    wb_t        wb;

    inst_u     rom [max_prog];
    word_t     model [num_regs];
    logic      exp_we [rows];
    reg_addr_t exp_waddr [rows];
    word_t     exp_wdata [rows];
    int        row_test [rows];
    string     test_names [max_tests];
    int        test_errors [max_tests];
    int        test_last_row [max_tests];
    int        num_tests;
    int        prog_len;
    int        cycle;
    int        pc_errors;
    int        timeout_cycles;
    integer    seed;

    cpu_top u_dut (
        .clk_i       (clk),
        .reset_i     (reset),
        .inst_addr_o (inst_addr),
        .inst_i      (inst),
        .wb_o        (wb)
    );

    // instruction ROM, nops past the end of the program
    always_comb begin
        if (inst_addr < inst_addr_t'(prog_len * 4)) begin
            inst = rom[inst_addr[7:2]];
        end else begin
            inst = '0;
        end
    end

    function automatic half_t rand_half();
        return half_t'($random(seed));
    endfunction

    task automatic start_test(input string name);
        test_names[num_tests]  = name;
        test_errors[num_tests] = 0;
        num_tests++;
    endtask

    task automatic expect_row(input int row, input logic we, input reg_addr_t waddr,
                              input word_t wdata);
        exp_we[row]                  = we;
        exp_waddr[row]               = waddr;
        exp_wdata[row]               = wdata;
        row_test[row]                = num_tests - 1;
        test_last_row[num_tests - 1] = row;
    endtask

    // the write-back shows wb_delay cycles after the fetch
    task automatic commit_inst(input inst_u w, input logic we, input reg_addr_t waddr,
                               input word_t wdata);
        rom[prog_len] = w;
        expect_row(prog_len + wb_delay, we, waddr, wdata);
        if (we && waddr != reg_zero) begin
            model[waddr] = wdata;
        end
        prog_len++;
    endtask

    task automatic emit_imm(input logic [5:0] opcode, input reg_addr_t rt, input reg_addr_t rs,
                            input half_t imm);
        inst_u w;
        word_t ext;
        word_t res;
        w.i.opcode = opcode;
        w.i.rs     = rs;
        w.i.rt     = rt;
        w.i.imm    = imm;
        ext        = {16'h0000, imm};
        case (opcode)
            opcode_ori:  res = model[rs] | ext;
            opcode_andi: res = model[rs] & ext;
            opcode_xori: res = model[rs] ^ ext;
            default:     res = {imm, 16'h0000};
        endcase
        commit_inst(w, 1'b1, rt, res);
    endtask

    task automatic emit_reg(input logic [5:0] funct, input reg_addr_t rd, input reg_addr_t rs,
                            input reg_addr_t rt);
        inst_u w;
        word_t res;
        w          = '0;
        w.r.opcode = opcode_special;
        w.r.rs     = rs;
        w.r.rt     = rt;
        w.r.rd     = rd;
        w.r.funct  = funct;
        case (funct)
            funct_or:  res = model[rs] | model[rt];
            funct_and: res = model[rs] & model[rt];
            funct_xor: res = model[rs] ^ model[rt];
            default:   res = ~(model[rs] | model[rt]);
        endcase
        commit_inst(w, 1'b1, rd, res);
    endtask

    task automatic emit_unknown(input inst_u w);
        commit_inst(w, 1'b0, reg_zero, '0);
    endtask

    task automatic build_program();
        inst_u w;
        for (int i = 0; i < max_prog; i++) begin
            rom[i] = '0;
        end
        for (int i = 0; i < num_regs; i++) begin
            model[i] = '0;
        end
        start_test("reset_state");
        for (int r = 0; r < wb_delay; r++) begin
            expect_row(r, 1'b0, reg_zero, '0);
        end
        start_test("imm_ops");
        emit_imm(opcode_ori, 5'd1, 5'd0, rand_half());
        emit_imm(opcode_ori, 5'd2, 5'd0, rand_half());
        emit_imm(opcode_andi, 5'd3, 5'd1, rand_half());
        emit_imm(opcode_xori, 5'd4, 5'd2, rand_half());
        emit_imm(opcode_lui, 5'd5, 5'd0, rand_half());
        // distance 1 uses the execute path, distance 2 the register file bypass
        start_test("rr_dependences");
        emit_imm(opcode_ori, 5'd5, 5'd5, rand_half());
        emit_reg(funct_or, 5'd6, 5'd5, 5'd1);
        emit_reg(funct_and, 5'd7, 5'd6, 5'd5);
        emit_reg(funct_xor, 5'd8, 5'd7, 5'd6);
        emit_reg(funct_nor, 5'd9, 5'd8, 5'd6);
        emit_reg(funct_or, 5'd10, 5'd9, 5'd7);
        emit_reg(funct_xor, 5'd10, 5'd10, 5'd4);
        start_test("reg_zero");
        emit_imm(opcode_ori, 5'd0, 5'd0, rand_half());
        emit_reg(funct_or, 5'd11, 5'd0, 5'd0);
        emit_imm(opcode_xori, 5'd12, 5'd0, rand_half());
        emit_reg(funct_nor, 5'd13, 5'd0, 5'd12);
        start_test("unknown_enc");
        w          = '0;
        w.i.opcode = 6'b000010;
        w.i.rt     = 5'd12;
        w.i.imm    = rand_half();
        emit_unknown(w);
        w          = '0;
        w.r.opcode = opcode_special;
        w.r.rs     = 5'd1;
        w.r.rt     = 5'd2;
        w.r.rd     = 5'd12;
        w.r.funct  = 6'b100000;
        emit_unknown(w);
        emit_reg(funct_or, 5'd14, 5'd12, 5'd0);
    endtask

    task automatic report_test(input int t);
        $display("%s: %0d errors", test_names[t], test_errors[t]);
    endtask

    task automatic check_cycle();
        int t;
        t = row_test[cycle];
        if (inst_addr !== inst_addr_t'(cycle * 4)) begin
            pc_errors++;
            $display("Fail pc_step expected %h actual %h", cycle * 4, inst_addr);
        end
        if (wb.we !== exp_we[cycle] || (exp_we[cycle] &&
            (wb.waddr !== exp_waddr[cycle] || wb.wdata !== exp_wdata[cycle]))) begin
            test_errors[t]++;
            $display("Fail %s expected we=%b r%0d=%h actual we=%b r%0d=%h", test_names[t],
                     exp_we[cycle], exp_waddr[cycle], exp_wdata[cycle],
                     wb.we, wb.waddr, wb.wdata);
        end
        if (cycle == test_last_row[t]) begin
            report_test(t);
        end
    endtask

    initial begin
        clk = 1'b0;
        forever begin
            #5 clk = ~clk;
        end
    end

    // limit follows the program length once it is built
    initial begin
        timeout_cycles = 0;
        while (timeout_cycles < prog_len + 20) begin
            @(posedge clk);
            if (!reset) begin
                timeout_cycles++;
            end
        end
        $display("run stopped at the cycle limit of %0d cycles", prog_len + 20);
        $display("Test failed");
        $finish;
    end

    initial begin
        int failed_tests;
        reset     = 1'b1;
        seed      = 19313;
        num_tests = 0;
        prog_len  = 0;
        pc_errors = 0;
        build_program();
        repeat (2) @(posedge clk);
        #1 reset = 1'b0;
        for (cycle = 0; cycle < prog_len + wb_delay; cycle++) begin
            @(negedge clk);
            check_cycle();
        end
        $display("pc_step: %0d errors", pc_errors);
        failed_tests = (pc_errors != 0) ? 1 : 0;
        for (int t = 0; t < num_tests; t++) begin
            if (test_errors[t] != 0) begin
                failed_tests++;
            end
        end
        $display("%0d tests, %0d with errors, %0d assertion errors", num_tests + 1,
                 failed_tests, u_dut.u_assertions.error_count);
        if (failed_tests == 0 && u_dut.u_assertions.error_count == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== list.f ====
common/cpu_pkg.sv
source/fetch.sv
decode/regfile.sv
decode/id.sv
source/ex.sv
source/cpu_top.sv
dv/cpu_assertions.sv
dv/cpu_tb.sv

// ==== Bender.yml ====
package:
  name: cpu

sources:
  - files:
      - common/cpu_pkg.sv
      - source/fetch.sv
      - decode/regfile.sv
      - decode/id.sv
      - source/ex.sv
      - source/cpu_top.sv
  - target: test
    files:
      - dv/cpu_assertions.sv
      - dv/cpu_tb.sv
